//--- vlog.f
+incdir+sim
verilog/demosaic_pkg.sv
verilog/raster_counter.sv
verilog/line_window.sv
verilog/beat_delay.sv
verilog/green_estimator.sv
verilog/frame_threshold.sv
verilog/demosaic_acpi_green.sv
sim/tb_demosaic.sv

//--- sim/demosaic_model.svh
`ifndef DEMOSAIC_MODEL_SVH
`define DEMOSAIC_MODEL_SVH

localparam int SITE_GREEN = 0;
localparam int SITE_RED   = 1;
localparam int SITE_BLUE  = 2;

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(logic [15:0] s);
	logic fb;
	fb = s[15] ^ s[13] ^ s[12] ^ s[10];
	return {s[14:0], fb};
endfunction

// Green on the diagonal, blue on even rows, red on odd rows
function automatic int site_of(int x, int y);
	if ((x % 2) == (y % 2)) begin
		return SITE_GREEN;
	end else if ((y % 2) == 0) begin
		return SITE_BLUE;
	end
	return SITE_RED;
endfunction

// Operand a is missing at pos 0, operand b at pos last
function automatic int edge_gradient(int a, int b, int pos, int last);
	int aa;
	int bb;
	aa = (pos == 0) ? 0 : a;
	bb = (pos == last) ? 0 : b;
	return (aa > bb) ? aa - bb : bb - aa;
endfunction

// Falls back to the single neighbour inside the frame
function automatic int dir_mean(int a, int b, int pos, int last);
	if (pos == 0) begin
		return b;
	end else if (pos == last) begin
		return a;
	end
	return (a + b) / 2;
endfunction

function automatic int green_of(int l, int r, int u, int d, int x, int y, int w, int h);
	int gh;
	int gv;
	int hg;
	int vg;
	gh = dir_mean(l, r, x, w - 1);
	gv = dir_mean(u, d, y, h - 1);
	hg = edge_gradient(l, r, x, w - 1);
	vg = edge_gradient(u, d, y, h - 1);
	if (hg > vg) begin
		return gv;
	end else if (hg < vg) begin
		return gh;
	end
	return (gh + gv) / 2;
endfunction

function automatic int activity_of(int l, int r, int u, int d, int x, int y, int w, int h);
	return edge_gradient(l, r, x, w - 1) + edge_gradient(u, d, y, h - 1);
endfunction

// First level whose bound lies above the sum
function automatic int threshold_of(int sum, int b0, int b1, int b2, int b3);
	if (sum < b0) begin
		return 50;
	end else if (sum < b1) begin
		return 40;
	end else if (sum < b2) begin
		return 20;
	end else if (sum < b3) begin
		return 15;
	end
	return 8;
endfunction

`endif

//--- sim/tb_demosaic.sv
`timescale 1ns/10ps
`default_nettype none

module tb_demosaic import demosaic_pkg::*; ();

	localparam int W         = 8;
	localparam int H         = 6;
	localparam int NPIX      = W * H;
	localparam int FRAME_LEN = W * (H + 1) + 1;
	// Enough beats to push the last pixel and its frame_done out
	localparam int FLUSH     = 6;
	localparam int TOTAL     = 2 * FRAME_LEN + FLUSH;
	localparam int LIMIT     = 4 * TOTAL + 100;

	logic   clk       = 1'b0;
	logic   reset     = 1'b1;
	pixel_t pix       = '0;
	logic   pix_valid = 1'b0;
	rgb_t   rgb;
	logic   out_valid;
	pixel_t t_value;
	logic   frame_done;

	logic [15:0] lfsr = 16'd20;
	pixel_t      img [2][NPIX];
	int          out_count  = 0;
	int          done_count = 0;
	int          cycles     = 0;
	pixel_t      held_t     = '0;
	logic        done_due   = 1'b0;

	`include "demosaic_model.svh"

	demosaic_acpi_green #(
		.WIDTH    (W),
		.HEIGHT   (H),
		.T_BOUNDS ({32'd3200, 32'd2400, 32'd1600, 32'd800})
	) uut (
		.clk        (clk),
		.reset      (reset),
		.pix        (pix),
		.pix_valid  (pix_valid),
		.rgb        (rgb),
		.out_valid  (out_valid),
		.t_value    (t_value),
		.frame_done (frame_done)
	);

	always #2 clk = ~clk;

	task automatic stop_with_failure(string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic value_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
		stop_with_failure($sformatf("CHECK FAILED %s expected %h got %h", name, expected, actual));
	endtask

	function automatic logic [7:0] draw_bits(int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic int pixel_at(int f, int x, int y);
		if (x < 0 || x >= W || y < 0 || y >= H) begin
			return 0;
		end
		return img[f][y * W + x];
	endfunction

	function automatic rgb_t expected_rgb(int f, int n);
		int   x;
		int   y;
		int   c;
		int   g;
		rgb_t e;
		x = n % W;
		y = n / W;
		c = pixel_at(f, x, y);
		g = green_of(pixel_at(f, x - 1, y), pixel_at(f, x + 1, y),
			pixel_at(f, x, y - 1), pixel_at(f, x, y + 1), x, y, W, H);
		e = '0;
		case (site_of(x, y))
			SITE_RED: begin
				e.r = pixel_t'(c);
				e.g = pixel_t'(g);
			end
			SITE_BLUE: begin
				e.g = pixel_t'(g);
				e.b = pixel_t'(c);
			end
			default: e.g = pixel_t'(c);
		endcase
		return e;
	endfunction

	// Gradient activity of one frame, non-green sites only
	function automatic int frame_activity(int f);
		int sum;
		sum = 0;
		for (int y = 0; y < H; y++) begin
			for (int x = 0; x < W; x++) begin
				if (site_of(x, y) != SITE_GREEN) begin
					sum += activity_of(pixel_at(f, x - 1, y), pixel_at(f, x + 1, y),
						pixel_at(f, x, y - 1), pixel_at(f, x, y + 1), x, y, W, H);
				end
			end
		end
		return sum;
	endfunction

	initial begin : stimulus
		pixel_t v;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int f = 0; f < 2; f++) begin
			for (int i = 0; i < FRAME_LEN; i++) begin
				// About one cycle in four is a stall
				while (draw_bits(2) == 8'd0) begin
					pix_valid = 1'b0;
					@(posedge clk);
					#1;
				end
				// Second frame is low contrast, so its threshold differs
				v = (f == 0) ? draw_bits(8) : draw_bits(5);
				if (i < NPIX) begin
					img[f][i] = v;
				end
				pix = v;
				pix_valid = 1'b1;
				@(posedge clk);
				#1;
			end
		end
		for (int i = 0; i < FLUSH; i++) begin
			pix = '0;
			pix_valid = 1'b1;
			@(posedge clk);
			#1;
		end
		pix_valid = 1'b0;
		while (done_count < 2) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		if (out_count == 2 * NPIX && done_count == 2) begin
			$display(">>> PASS");
			$finish;
		end else begin
			stop_with_failure($sformatf("Run ended with %0d pixels and %0d frame ends",
				out_count, done_count));
		end
	end

	// Outputs are stable at the falling edge
	always @(negedge clk) begin : compare
		rgb_t   exp_rgb;
		pixel_t exp_t;
		if (reset) begin
			assert (rgb === '0) else value_mismatch("rgb", '0, rgb);
		end
		if (pix_valid !== 1'b1) begin
			assert (out_valid === 1'b0) else value_mismatch("out_valid", 0, out_valid);
			assert (frame_done === 1'b0) else value_mismatch("frame_done", 0, frame_done);
		end else begin
			// frame_done belongs on the first beat after the frame's last pixel
			assert (frame_done === done_due) else value_mismatch("frame_done", done_due, frame_done);
			done_due = 1'b0;
		end
		// t_value may only move once the frame's last pixel is out
		if (out_count != (done_count + 1) * NPIX) begin
			assert (t_value === held_t) else value_mismatch("t_value", held_t, t_value);
		end
		if (out_valid === 1'b1) begin
			assert (out_count < 2 * NPIX) else stop_with_failure("More pixels came out than were sent");
			exp_rgb = expected_rgb(out_count / NPIX, out_count % NPIX);
			assert (rgb === exp_rgb) else value_mismatch("rgb", exp_rgb, rgb);
			out_count++;
			if (out_count % NPIX == 0) begin
				done_due = 1'b1;
			end
		end
		if (frame_done === 1'b1) begin
			assert (out_count == (done_count + 1) * NPIX)
			else stop_with_failure("frame_done came before all pixels of its frame");
			exp_t = pixel_t'(threshold_of(frame_activity(done_count), 800, 1600, 2400, 3200));
			assert (t_value === exp_t) else value_mismatch("t_value", exp_t, t_value);
			held_t = exp_t;
			done_count++;
		end
	end

	always @(posedge clk) begin : watchdog
		cycles++;
		if (cycles >= LIMIT) begin
			stop_with_failure($sformatf("Timeout after %0d cycles with %0d pixels and %0d frame ends",
				cycles, out_count, done_count));
		end
	end

endmodule

`default_nettype wire

//--- verilog/demosaic_acpi_green.sv
`timescale 1ns/10ps
`default_nettype none

module demosaic_acpi_green import demosaic_pkg::*; #(
	parameter int              WIDTH    = DEF_WIDTH,
	parameter int              HEIGHT   = DEF_HEIGHT,
	parameter activity_t [3:0] T_BOUNDS = DEF_T_BOUNDS
) (
	input  wire logic   clk,
	input  wire logic   reset,
	input  wire pixel_t pix,
	input  wire logic   pix_valid,
	output rgb_t        rgb,
	output logic        out_valid,
	output pixel_t      t_value,
	output logic        frame_done
);

	tag_t      tag;
	window_t   win;
	activity_t act_inc;
	logic      act_en;
	logic      frame_last;

	raster_counter #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) u_counter (
		.clk       (clk),
		.reset     (reset),
		.pix_valid (pix_valid),
		.tag       (tag)
	);

	line_window #(.WIDTH(WIDTH)) u_window (
		.clk       (clk),
		.reset     (reset),
		.pix       (pix),
		.pix_valid (pix_valid),
		.win       (win)
	);

	green_estimator #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) u_green (
		.clk        (clk),
		.reset      (reset),
		.pix_valid  (pix_valid),
		.win        (win),
		.tag        (tag),
		.rgb        (rgb),
		.out_valid  (out_valid),
		.act_inc    (act_inc),
		.act_en     (act_en),
		.frame_last (frame_last)
	);

	frame_threshold #(.T_BOUNDS(T_BOUNDS)) u_threshold (
		.clk        (clk),
		.reset      (reset),
		.pix_valid  (pix_valid),
		.act_inc    (act_inc),
		.act_en     (act_en),
		.frame_last (frame_last),
		.t_value    (t_value),
		.frame_done (frame_done)
	);

endmodule

`default_nettype wire

//--- verilog/frame_threshold.sv
`timescale 1ns/10ps
`default_nettype none

module frame_threshold import demosaic_pkg::*; #(
	parameter activity_t [3:0] T_BOUNDS = DEF_T_BOUNDS
) (
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire logic      pix_valid,
	input  wire activity_t act_inc,
	input  wire logic      act_en,
	input  wire logic      frame_last,
	output pixel_t         t_value,
	output logic           frame_done
);

	activity_t sum;
	activity_t total;
	logic      done_q;

	// First level whose bound exceeds the sum
	function automatic pixel_t level_of(activity_t s);
		pixel_t lvl;
		lvl = T_LEVELS[4];
		for (int i = 3; i >= 0; i--) begin
			if (s < T_BOUNDS[i]) begin
				lvl = T_LEVELS[i];
			end
		end
		return lvl;
	endfunction

	assign total = act_en ? sum + act_inc : sum;

	always_ff @(posedge clk) begin
		if (reset) begin
			sum     <= '0;
			t_value <= '0;
			done_q  <= 1'b0;
		end else if (pix_valid) begin
			done_q <= frame_last;
			if (frame_last) begin
				t_value <= level_of(total);
				sum     <= '0;
			end else begin
				sum <= total;
			end
		end
	end

	// Pending done is shown on the next beat only
	assign frame_done = done_q & pix_valid;

endmodule

`default_nettype wire

//--- verilog/green_estimator.sv
`timescale 1ns/10ps
`default_nettype none

module green_estimator import demosaic_pkg::*; #(
	parameter int WIDTH  = DEF_WIDTH,
	parameter int HEIGHT = DEF_HEIGHT
) (
	input  wire logic    clk,
	input  wire logic    reset,
	input  wire logic    pix_valid,
	input  wire window_t win,
	input  wire tag_t    tag,
	output rgb_t         rgb,
	output logic         out_valid,
	output activity_t    act_inc,
	output logic         act_en,
	output logic         frame_last
);

	localparam coord_t LAST_X = coord_t'(WIDTH - 1);
	localparam coord_t LAST_Y = coord_t'(HEIGHT - 1);

	function automatic pixel_t abs_diff(pixel_t a, pixel_t b);
		return (a > b) ? a - b : b - a;
	endfunction

	// Truncated mean
	function automatic pixel_t mean2(pixel_t a, pixel_t b);
		logic [8:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[8:1];
	endfunction

	// Stage 1
	pixel_t h_a1, h_b1, v_a1, v_b1;
	pixel_t gh1, gv1;

	// Stage 2
	pixel_t h2, v2;
	pixel_t gh2, gv2, ghv2;

	// Stage 3
	pixel_t     green3;
	logic [8:0] act3;
	tag_t       tag3;
	pixel_t     centre3;

	beat_delay #(.payload_t(tag_t), .DEPTH(3)) tag_delay (
		.clk       (clk),
		.reset     (reset),
		.pix_valid (pix_valid),
		.din       (tag),
		.dout      (tag3)
	);

	beat_delay #(.payload_t(pixel_t), .DEPTH(3)) centre_delay (
		.clk       (clk),
		.reset     (reset),
		.pix_valid (pix_valid),
		.din       (win.mid_c),
		.dout      (centre3)
	);

	always_ff @(posedge clk) begin
		if (pix_valid) begin
			// Neighbours outside the frame count as zero
			h_a1 <= (tag.x == '0) ? '0 : win.mid_l;
			h_b1 <= (tag.x == LAST_X) ? '0 : win.mid_r;
			v_a1 <= (tag.y == '0) ? '0 : win.up_c;
			v_b1 <= (tag.y == LAST_Y) ? '0 : win.dn_c;

			if (tag.x == '0) begin
				gh1 <= win.mid_r;
			end else if (tag.x == LAST_X) begin
				gh1 <= win.mid_l;
			end else begin
				gh1 <= mean2(win.mid_l, win.mid_r);
			end

			if (tag.y == '0) begin
				gv1 <= win.dn_c;
			end else if (tag.y == LAST_Y) begin
				gv1 <= win.up_c;
			end else begin
				gv1 <= mean2(win.up_c, win.dn_c);
			end

			h2   <= abs_diff(h_a1, h_b1);
			v2   <= abs_diff(v_a1, v_b1);
			gh2  <= gh1;
			gv2  <= gv1;
			ghv2 <= mean2(gh1, gv1);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			green3 <= '0;
			act3   <= '0;
		end else if (pix_valid) begin
			// Interpolate along the direction with the smaller gradient
			if (h2 > v2) begin
				green3 <= gv2;
			end else if (h2 < v2) begin
				green3 <= gh2;
			end else begin
				green3 <= ghv2;
			end
			act3 <= {1'b0, h2} + {1'b0, v2};
		end
	end

	always_comb begin
		rgb = '0;
		case (tag3.phase)
			PH_RED: begin
				rgb.r = centre3;
				rgb.g = green3;
			end
			PH_BLUE: begin
				rgb.g = green3;
				rgb.b = centre3;
			end
			default: rgb.g = centre3;
		endcase
	end

	assign out_valid  = tag3.live & pix_valid;
	assign act_inc    = activity_t'(act3);
	assign act_en     = tag3.live && (tag3.phase != PH_GREEN);
	assign frame_last = tag3.last;

endmodule

`default_nettype wire

//--- verilog/beat_delay.sv
`timescale 1ns/10ps
`default_nettype none

module beat_delay import demosaic_pkg::*; #(
	parameter type payload_t = pixel_t,
	parameter int  DEPTH     = 1
) (
	input  wire logic     clk,
	input  wire logic     reset,
	input  wire logic     pix_valid,
	input  wire payload_t din,
	output payload_t      dout
);

	payload_t stage [DEPTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			stage <= '{default: '0};
		end else if (pix_valid) begin
			stage[0] <= din;
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign dout = stage[DEPTH-1];

endmodule

`default_nettype wire

//--- verilog/line_window.sv
`timescale 1ns/10ps
`default_nettype none

module line_window import demosaic_pkg::*; #(
	parameter int WIDTH = DEF_WIDTH
) (
	input  wire logic   clk,
	input  wire logic   reset,
	input  wire pixel_t pix,
	input  wire logic   pix_valid,
	output window_t     win
);

	localparam int AW = (WIDTH > 1) ? $clog2(WIDTH) : 1;

	// Line 0 holds the previous line, line 1 the one before it
	pixel_t line0 [WIDTH];
	pixel_t line1 [WIDTH];

	logic [AW-1:0] col;
	pixel_t        tap0;
	pixel_t        tap1;

	assign tap0 = line0[col];
	assign tap1 = line1[col];

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
		end else if (pix_valid) begin
			if (col == AW'(WIDTH - 1)) begin
				col <= '0;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// Each line is a circular buffer of exactly one line delay
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			line0[col] <= pix;
			line1[col] <= tap0;
		end
	end

	// Newest column enters on the right
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			win.up_l  <= win.up_c;
			win.up_c  <= win.up_r;
			win.up_r  <= tap1;
			win.mid_l <= win.mid_c;
			win.mid_c <= win.mid_r;
			win.mid_r <= tap0;
			win.dn_l  <= win.dn_c;
			win.dn_c  <= win.dn_r;
			win.dn_r  <= pix;
		end
	end

endmodule

`default_nettype wire

//--- verilog/raster_counter.sv
`timescale 1ns/10ps
`default_nettype none

module raster_counter import demosaic_pkg::*; #(
	parameter int WIDTH  = DEF_WIDTH,
	parameter int HEIGHT = DEF_HEIGHT
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic pix_valid,
	output tag_t      tag
);

	// Real pixels plus one padding line and one extra sample
	localparam logic [31:0] LAST_CNT = 32'(WIDTH * (HEIGHT + 1));
	localparam coord_t      LAST_X   = coord_t'(WIDTH - 1);
	localparam coord_t      PAD_Y    = coord_t'(HEIGHT + 1);

	logic [31:0]  cnt;
	coord_t       cx;
	coord_t       cy;
	bayer_phase_t phase;

	always_comb begin
		case ({cy[0], cx[0]})
			2'b01: phase = PH_BLUE;
			2'b10: phase = PH_RED;
			default: phase = PH_GREEN;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			// First centre after reset lies in the padding line
			cx  <= '0;
			cy  <= coord_t'(HEIGHT);
			tag <= '0;
		end else if (pix_valid) begin
			tag.x     <= cx;
			tag.y     <= cy;
			tag.phase <= phase;
			tag.live  <= (cy < coord_t'(HEIGHT));
			tag.last  <= (cnt == LAST_CNT);

			if (cnt == LAST_CNT) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end

			// Single trailing sample on the second padding line wraps the centre
			if (cy == PAD_Y) begin
				cx <= '0;
				cy <= '0;
			end else if (cx == LAST_X) begin
				cx <= '0;
				cy <= cy + 1'b1;
			end else begin
				cx <= cx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/demosaic_pkg.sv
`default_nettype none

package demosaic_pkg;

	typedef logic [7:0] pixel_t;
	typedef logic [15:0] coord_t;
	typedef logic [31:0] activity_t;

	// Colour of the sensor site under the window centre
	typedef enum logic [1:0] {
		PH_GREEN = 2'd0,
		PH_RED   = 2'd1,
		PH_BLUE  = 2'd2
	} bayer_phase_t;

	// 3x3 neighbourhood with rows top to bottom and columns left to right
	typedef struct packed {
		pixel_t up_l;
		pixel_t up_c;
		pixel_t up_r;
		pixel_t mid_l;
		pixel_t mid_c;
		pixel_t mid_r;
		pixel_t dn_l;
		pixel_t dn_c;
		pixel_t dn_r;
	} window_t;

	// Describes the window centre
	typedef struct packed {
		coord_t       x;
		coord_t       y;
		bayer_phase_t phase;
		logic         live;
		logic         last;
	} tag_t;

	typedef struct packed {
		pixel_t r;
		pixel_t g;
		pixel_t b;
	} rgb_t;

	localparam int DEF_WIDTH  = 1920;
	localparam int DEF_HEIGHT = 1080;

	// Activity bounds in ascending order, index 0 first
	localparam activity_t [3:0] DEF_T_BOUNDS = {32'd292965, 32'd146484, 32'd102539, 32'd73242};

	// Threshold per bound, last entry used above every bound
	localparam pixel_t [4:0] T_LEVELS = {8'd8, 8'd15, 8'd20, 8'd40, 8'd50};

endpackage

`default_nettype wire
